/* compile.f */
lockstep_pkg.sv
shadow_reset_ctrl.sv
input_delay_line.sv
bus_intg_check.sv
sum_core.sv
output_compare.sv
lockstep_top.sv
tb_lockstep.sv

/* Makefile */
# Verilator build and run of the lockstep testbench

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_lockstep -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* tb_lockstep.sv */
// Lockstep testbench with main core, memory model, fault injection and alert checks
module tb_lockstep;
  timeunit 1ns;
  timeprecision 1ps;
  import lockstep_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int TEST_CYCLES   = 1000;
  localparam int RST_CYCLES    = 16;
  // Comparison opens on the third edge after reset release
  localparam int EN_CYCLE      = RST_CYCLES + 3;
  localparam int ALERT_LAT     = 3;
  localparam int CORRUPT_START = 350;
  localparam int PROG_WORDS    = 220;

  logic              clk_i;
  logic              rst_ni;
  logic              fetch_enable;
  logic [ADDR_W-1:0] boot_addr;
  logic              main_req;
  logic              main_we;
  logic [BE_W-1:0]   main_be;
  logic [ADDR_W-1:0] main_addr;
  logic [DATA_W-1:0] main_wdata;
  logic              gnt;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic [INTG_W-1:0] rdata_intg;
  logic              err;
  logic [ADDR_W-1:0] fault_mask;
  logic [INTG_W-1:0] wdata_intg;
  logic              alert_int;
  logic              alert_bus;

  logic [DATA_W-1:0] mem [256];
  bit                pend_valid;
  int                pend_wait;
  bit                pend_we;
  logic [7:0]        pend_idx;
  logic [DATA_W-1:0] pend_wdata;
  int                fault_q [$];
  int                corrupt_q [$];
  int                cyc;
  int                chk_cnt;
  int                err_cnt;
  int                fault_cnt;
  int                corrupt_cnt;
  int                wr_corrupt_cnt;
  int                store_cnt;

  // Inverted Hsiao 39/32 check bits
  function automatic logic [6:0] intg_encode(input logic [31:0] data);
    logic [31:0] masks [7];
    logic [6:0]  chk;
    masks = '{32'h2606_BD25, 32'hDEBA_8050, 32'h413D_89AA, 32'h3123_4ED1,
              32'hC2C1_323B, 32'h2DCC_624C, 32'h9850_5586};
    for (int i = 0; i < 7; i++) begin
      chk[i] = ^(data & masks[i]);
    end
    return chk ^ 7'h2A;
  endfunction

  function automatic bit fault_scheduled(input int n);
    return n == 14 || n == 15 || n == 16 || n == 420 || n == 557 || n == 558 || n == 790;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("MISMATCH %s cycle %0d: got 0x%h, expected 0x%h", name, cyc, actual, expected);
    end
  endtask

  // Add, xor and store words up to a halt with store targets in words 224 to 255
  task automatic load_program();
    int unsigned sel;
    for (int i = 0; i < 256; i++) begin
      sel = $urandom % 8;
      if (i >= PROG_WORDS) begin
        mem[8'(i)] = $urandom;
      end else if (i == PROG_WORDS - 1) begin
        mem[8'(i)] = {OP_HALT, 30'h0};
      end else begin
        case (sel)
          0, 1, 2, 3: mem[8'(i)] = {OP_ADD, 30'($urandom)};
          4, 5:       mem[8'(i)] = {OP_XOR, 30'($urandom)};
          default:    mem[8'(i)] = {OP_STORE, 30'(224 + $urandom % 32)};
        endcase
      end
    end
  endtask

  //////////////////////////////
  // Memory model with one access outstanding

  task automatic drive_memory(input int n);
    rvalid     = 1'b0;
    gnt        = 1'b0;
    rdata      = $urandom;
    rdata_intg = 7'($urandom);
    if (pend_valid) begin
      if (pend_wait > 0) begin
        pend_wait--;
      end else begin
        pend_valid = 1'b0;
        rvalid     = 1'b1;
        if (pend_we) begin
          mem[pend_idx] = pend_wdata;
          store_cnt++;
        end else begin
          rdata = mem[pend_idx];
        end
        rdata_intg = intg_encode(rdata);
        if (n >= CORRUPT_START && $urandom % 5 == 0) begin
          rdata_intg = rdata_intg ^ 7'(1 << ($urandom % 7));
          // Write responses carry no checked data
          if (!pend_we) begin
            corrupt_q.push_back(n);
            corrupt_cnt++;
          end else begin
            wr_corrupt_cnt++;
          end
        end
      end
    end
    if (main_req && !pend_valid && $urandom % 4 != 0) begin
      gnt        = 1'b1;
      pend_valid = 1'b1;
      pend_wait  = $urandom % 3;
      pend_we    = main_we;
      pend_idx   = main_addr[9:2];
      pend_wdata = main_wdata;
    end
  endtask

  sum_core u_main_core (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable),
    .boot_addr_i    (boot_addr),
    .data_gnt_i     (gnt),
    .data_rvalid_i  (rvalid),
    .data_rdata_i   (rdata),
    .data_err_i     (err),
    .data_req_o     (main_req),
    .data_we_o      (main_we),
    .data_be_o      (main_be),
    .data_addr_o    (main_addr),
    .data_wdata_o   (main_wdata)
  );

  lockstep_top lockstep_top_i (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .fetch_enable_i         (fetch_enable),
    .boot_addr_i            (boot_addr),
    .data_req_i             (main_req),
    .data_we_i              (main_we),
    .data_be_i              (main_be),
    .data_addr_i            (main_addr ^ fault_mask),
    .data_wdata_i           (main_wdata),
    .data_gnt_i             (gnt),
    .data_rvalid_i          (rvalid),
    .data_rdata_i           (rdata),
    .data_rdata_intg_i      (rdata_intg),
    .data_err_i             (err),
    .data_wdata_intg_o      (wdata_intg),
    .alert_major_internal_o (alert_int),
    .alert_major_bus_o      (alert_bus)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  //////////////////////////////
  // Stimulus

  initial begin
    void'($urandom(32'h54b6_878b));
    rst_ni         = 1'b0;
    fetch_enable   = 1'b0;
    // Boot address above the memory index bits
    boot_addr      = 32'h0000_0400;
    gnt            = 1'b0;
    rvalid         = 1'b0;
    rdata          = '0;
    rdata_intg     = '0;
    err            = 1'b0;
    fault_mask     = '0;
    pend_valid     = 1'b0;
    pend_wait      = 0;
    cyc            = -1;
    chk_cnt        = 0;
    err_cnt        = 0;
    fault_cnt      = 0;
    corrupt_cnt    = 0;
    wr_corrupt_cnt = 0;
    store_cnt      = 0;
    load_program();
    for (int n = 0; n < TEST_CYCLES; n++) begin
      @(posedge clk_i);
      #1;
      cyc          = n;
      rst_ni       = (n >= RST_CYCLES);
      fetch_enable = (n >= RST_CYCLES + 2);
      fault_mask   = '0;
      if (fault_scheduled(n)) begin
        fault_mask = $urandom | 32'h1;
        fault_q.push_back(n);
        fault_cnt++;
      end
      drive_memory(n);
    end
    @(posedge clk_i);
    if (corrupt_cnt == 0 || wr_corrupt_cnt == 0 || store_cnt == 0) begin
      err_cnt++;
      $display("Run ended before covering corrupted reads, corrupted write responses and stores");
    end
    $display("Summary: %0d checks, %0d errors, %0d faults, %0d corrupted reads, %0d stores",
             chk_cnt, err_cnt, fault_cnt, corrupt_cnt, store_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Predicted alerts and write integrity checked mid-cycle
  always @(negedge clk_i) begin
    logic exp_int;
    logic exp_bus;
    if (cyc >= 0) begin
      exp_int = 1'b0;
      exp_bus = 1'b0;
      while (fault_q.size() > 0 && fault_q[0] + ALERT_LAT < cyc) begin
        void'(fault_q.pop_front());
      end
      if (fault_q.size() > 0 && fault_q[0] + ALERT_LAT == cyc && cyc >= EN_CYCLE) begin
        exp_int = 1'b1;
      end
      while (corrupt_q.size() > 0 && corrupt_q[0] + 1 < cyc) begin
        void'(corrupt_q.pop_front());
      end
      if (corrupt_q.size() > 0 && corrupt_q[0] + 1 == cyc) begin
        exp_bus = 1'b1;
      end
      check_value("alert_major_internal_o", 32'(alert_int), 32'(exp_int));
      check_value("alert_major_bus_o", 32'(alert_bus), 32'(exp_bus));
      check_value("data_wdata_intg_o", 32'(wdata_intg), 32'(intg_encode(main_wdata)));
    end
  end

  initial begin
    #(TEST_CYCLES * CLK_PERIOD + 400);
    $display("Timeout: the run went past its cycle budget without finishing");
    $display("Test failures found");
    $finish;
  end

endmodule

/* lockstep_top.sv */
// Lockstep checker top with reset control, input delay, integrity check, shadow core, compare
module lockstep_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             fetch_enable_i,
  input  logic [lockstep_pkg::ADDR_W-1:0]  boot_addr_i,
  input  logic                             data_req_i,
  input  logic                             data_we_i,
  input  logic [lockstep_pkg::BE_W-1:0]    data_be_i,
  input  logic [lockstep_pkg::ADDR_W-1:0]  data_addr_i,
  input  logic [lockstep_pkg::DATA_W-1:0]  data_wdata_i,
  input  logic                             data_gnt_i,
  input  logic                             data_rvalid_i,
  input  logic [lockstep_pkg::DATA_W-1:0]  data_rdata_i,
  input  logic [lockstep_pkg::INTG_W-1:0]  data_rdata_intg_i,
  input  logic                             data_err_i,
  output logic [lockstep_pkg::INTG_W-1:0]  data_wdata_intg_o,
  output logic                             alert_major_internal_o,
  output logic                             alert_major_bus_o
);
  import lockstep_pkg::*;

  logic              rst_shadow_n;
  logic              enable_cmp;
  logic              shadow_gnt;
  logic              shadow_rvalid;
  logic [DATA_W-1:0] shadow_rdata;
  logic              shadow_err;
  logic              shadow_fetch_enable;
  logic              rvalid_d1;
  logic [DATA_W-1:0] rdata_d1;
  logic [INTG_W-1:0] rdata_intg_d1;
  logic              shadow_req;
  logic              shadow_we;
  logic [BE_W-1:0]   shadow_be;
  logic [ADDR_W-1:0] shadow_addr;
  logic [DATA_W-1:0] shadow_wdata;

  //////////////////////////////
  // Input side

  shadow_reset_ctrl u_reset_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rst_shadow_no (rst_shadow_n),
    .enable_cmp_o  (enable_cmp)
  );

  input_delay_line u_input_delay (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .gnt_i           (data_gnt_i),
    .rvalid_i        (data_rvalid_i),
    .rdata_i         (data_rdata_i),
    .err_i           (data_err_i),
    .rdata_intg_i    (data_rdata_intg_i),
    .fetch_enable_i  (fetch_enable_i),
    .gnt_o           (shadow_gnt),
    .rvalid_o        (shadow_rvalid),
    .rdata_o         (shadow_rdata),
    .err_o           (shadow_err),
    .fetch_enable_o  (shadow_fetch_enable),
    .rvalid_d1_o     (rvalid_d1),
    .rdata_d1_o      (rdata_d1),
    .rdata_intg_d1_o (rdata_intg_d1)
  );

  bus_intg_check u_bus_intg (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .data_gnt_i        (data_gnt_i),
    .data_we_i         (data_we_i),
    .rvalid_d1_i       (rvalid_d1),
    .rdata_d1_i        (rdata_d1),
    .rdata_intg_d1_i   (rdata_intg_d1),
    .data_wdata_i      (data_wdata_i),
    .data_wdata_intg_o (data_wdata_intg_o),
    .bus_intg_err_o    (alert_major_bus_o)
  );

  //////////////////////////////
  // Shadow core

  sum_core u_shadow_core (
    .clk_i          (clk_i),
    .rst_ni         (rst_shadow_n),
    .fetch_enable_i (shadow_fetch_enable),
    .boot_addr_i    (boot_addr_i),
    .data_gnt_i     (shadow_gnt),
    .data_rvalid_i  (shadow_rvalid),
    .data_rdata_i   (shadow_rdata),
    .data_err_i     (shadow_err),
    .data_req_o     (shadow_req),
    .data_we_o      (shadow_we),
    .data_be_o      (shadow_be),
    .data_addr_o    (shadow_addr),
    .data_wdata_o   (shadow_wdata)
  );

  //////////////////////////////
  // Output side

  output_compare u_output_compare (
    .clk_i          (clk_i),
    .enable_cmp_i   (enable_cmp),
    .data_req_i     (data_req_i),
    .data_we_i      (data_we_i),
    .data_be_i      (data_be_i),
    .data_addr_i    (data_addr_i),
    .data_wdata_i   (data_wdata_i),
    .shadow_req_i   (shadow_req),
    .shadow_we_i    (shadow_we),
    .shadow_be_i    (shadow_be),
    .shadow_addr_i  (shadow_addr),
    .shadow_wdata_i (shadow_wdata),
    .mismatch_o     (alert_major_internal_o)
  );

endmodule

/* output_compare.sv */
// Main output delay line, shadow output register and lockstep mismatch compare
module output_compare (
  input  logic                             clk_i,
  input  logic                             enable_cmp_i,
  input  logic                             data_req_i,
  input  logic                             data_we_i,
  input  logic [lockstep_pkg::BE_W-1:0]    data_be_i,
  input  logic [lockstep_pkg::ADDR_W-1:0]  data_addr_i,
  input  logic [lockstep_pkg::DATA_W-1:0]  data_wdata_i,
  input  logic                             shadow_req_i,
  input  logic                             shadow_we_i,
  input  logic [lockstep_pkg::BE_W-1:0]    shadow_be_i,
  input  logic [lockstep_pkg::ADDR_W-1:0]  shadow_addr_i,
  input  logic [lockstep_pkg::DATA_W-1:0]  shadow_wdata_i,
  output logic                             mismatch_o
);
  import lockstep_pkg::*;

  // Fields packed as {req, we, be, addr, wdata}
  logic [2+BE_W+ADDR_W+DATA_W-1:0] main_in;
  logic [2+BE_W+ADDR_W+DATA_W-1:0] shadow_in;
  logic [2+BE_W+ADDR_W+DATA_W-1:0] main_q [OUTPUTS_OFFSET];
  logic [2+BE_W+ADDR_W+DATA_W-1:0] shadow_q;

  assign main_in   = {data_req_i, data_we_i, data_be_i, data_addr_i, data_wdata_i};
  assign shadow_in = {shadow_req_i, shadow_we_i, shadow_be_i, shadow_addr_i, shadow_wdata_i};

  //////////////////////////////
  // Output alignment

  always_ff @(posedge clk_i) begin
    main_q[0] <= main_in;
    for (int unsigned i = 1; i < OUTPUTS_OFFSET; i++) begin
      main_q[i] <= main_q[i-1];
    end
    shadow_q <= shadow_in;
  end

  // Any differing field is a lockstep fault
  assign mismatch_o = enable_cmp_i & (shadow_q != main_q[OUTPUTS_OFFSET-1]);

endmodule

/* sum_core.sv */
// Load, accumulate and store core, used as both main and shadow copy
module sum_core (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             fetch_enable_i,
  input  logic [lockstep_pkg::ADDR_W-1:0]  boot_addr_i,
  input  logic                             data_gnt_i,
  input  logic                             data_rvalid_i,
  input  logic [lockstep_pkg::DATA_W-1:0]  data_rdata_i,
  input  logic                             data_err_i,
  output logic                             data_req_o,
  output logic                             data_we_o,
  output logic [lockstep_pkg::BE_W-1:0]    data_be_o,
  output logic [lockstep_pkg::ADDR_W-1:0]  data_addr_o,
  output logic [lockstep_pkg::DATA_W-1:0]  data_wdata_o
);
  import lockstep_pkg::*;

  core_state_e       state_q;
  core_state_e       state_d;
  logic [ADDR_W-1:0] pc_q;
  logic [ADDR_W-1:0] pc_d;
  logic [DATA_W-1:0] acc_q;
  logic [DATA_W-1:0] acc_d;
  logic              store_q;
  logic              store_d;
  logic              st_addr_en;
  logic [ADDR_W-1:0] st_addr_q;
  opcode_e           op;
  logic [DATA_W-1:0] operand;

  assign op      = opcode_e'(data_rdata_i[DATA_W-1:DATA_W-2]);
  assign operand = {2'b00, data_rdata_i[DATA_W-3:0]};

  always_comb begin
    state_d    = state_q;
    pc_d       = pc_q;
    acc_d      = acc_q;
    store_d    = store_q;
    st_addr_en = 1'b0;
    unique case (state_q)
      ST_IDLE: begin
        if (fetch_enable_i) begin
          pc_d    = boot_addr_i;
          state_d = ST_REQ;
        end
      end
      ST_REQ: begin
        if (data_gnt_i) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (data_rvalid_i) begin
          state_d = ST_REQ;
          if (data_err_i) begin
            state_d = ST_DONE;
          end else if (store_q) begin
            // Write done, resume fetching at pc
            store_d = 1'b0;
          end else begin
            pc_d = pc_q + ADDR_W'(4);
            unique case (op)
              OP_ADD:   acc_d = acc_q + operand;
              OP_XOR:   acc_d = acc_q ^ operand;
              OP_STORE: begin
                store_d    = 1'b1;
                st_addr_en = 1'b1;
              end
              OP_HALT:  state_d = ST_DONE;
            endcase
          end
        end
      end
      ST_DONE: state_d = ST_DONE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      pc_q    <= '0;
      acc_q   <= '0;
      store_q <= 1'b0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      acc_q   <= acc_d;
      store_q <= store_d;
    end
  end

  // Word address of the store target
  always_ff @(posedge clk_i) begin
    if (st_addr_en) begin
      st_addr_q <= {data_rdata_i[DATA_W-3:0], 2'b00};
    end
  end

  assign data_req_o   = (state_q == ST_REQ);
  assign data_we_o    = store_q;
  assign data_be_o    = {BE_W{data_req_o}};
  assign data_addr_o  = store_q ? st_addr_q : pc_q;
  assign data_wdata_o = acc_q;

endmodule

/* bus_intg_check.sv */
// Read data integrity check and write data integrity generation, inverted SECDED 39/32
module bus_intg_check (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             data_gnt_i,
  input  logic                             data_we_i,
  input  logic                             rvalid_d1_i,
  input  logic [lockstep_pkg::DATA_W-1:0]  rdata_d1_i,
  input  logic [lockstep_pkg::INTG_W-1:0]  rdata_intg_d1_i,
  input  logic [lockstep_pkg::DATA_W-1:0]  data_wdata_i,
  output logic [lockstep_pkg::INTG_W-1:0]  data_wdata_intg_o,
  output logic                             bus_intg_err_o
);
  import lockstep_pkg::*;

  logic              we_gnt_q;
  logic              we_aligned_q;
  logic [INTG_W-1:0] rdata_intg_calc;
  logic [INTG_W-1:0] syndrome;

  function automatic logic [INTG_W-1:0] secded_enc(input logic [DATA_W-1:0] data);
    logic [INTG_W-1:0] chk;
    chk[0] = ^(data & SECDED_MASK_0);
    chk[1] = ^(data & SECDED_MASK_1);
    chk[2] = ^(data & SECDED_MASK_2);
    chk[3] = ^(data & SECDED_MASK_3);
    chk[4] = ^(data & SECDED_MASK_4);
    chk[5] = ^(data & SECDED_MASK_5);
    chk[6] = ^(data & SECDED_MASK_6);
    return chk ^ INTG_INVERT;
  endfunction

  //////////////////////////////
  // Read data check

  // Direction of the granted access, lined up with the delayed rvalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_gnt_q     <= 1'b0;
      we_aligned_q <= 1'b0;
    end else begin
      if (data_gnt_i) begin
        we_gnt_q <= data_we_i;
      end
      we_aligned_q <= we_gnt_q;
    end
  end

  assign rdata_intg_calc = secded_enc(rdata_d1_i);
  assign syndrome        = rdata_intg_calc ^ rdata_intg_d1_i;

  // Write responses carry no data, so only reads are checked
  assign bus_intg_err_o = rvalid_d1_i & ~we_aligned_q & (|syndrome);

  //////////////////////////////
  // Write data generation

  assign data_wdata_intg_o = secded_enc(data_wdata_i);

endmodule

/* input_delay_line.sv */
// Shift register delaying bus returns and fetch enable on their way to the shadow core
module input_delay_line (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             gnt_i,
  input  logic                             rvalid_i,
  input  logic [lockstep_pkg::DATA_W-1:0]  rdata_i,
  input  logic                             err_i,
  input  logic [lockstep_pkg::INTG_W-1:0]  rdata_intg_i,
  input  logic                             fetch_enable_i,
  output logic                             gnt_o,
  output logic                             rvalid_o,
  output logic [lockstep_pkg::DATA_W-1:0]  rdata_o,
  output logic                             err_o,
  output logic                             fetch_enable_o,
  output logic                             rvalid_d1_o,
  output logic [lockstep_pkg::DATA_W-1:0]  rdata_d1_o,
  output logic [lockstep_pkg::INTG_W-1:0]  rdata_intg_d1_o
);
  import lockstep_pkg::*;

  // Flags per stage are {fetch_enable, err, rvalid, gnt}
  logic [3:0]        flags_q [LOCKSTEP_OFFSET];
  logic [DATA_W-1:0] rdata_q [LOCKSTEP_OFFSET];
  logic [INTG_W-1:0] rdata_intg_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < LOCKSTEP_OFFSET; i++) begin
        flags_q[i] <= '0;
        rdata_q[i] <= '0;
      end
      rdata_intg_q <= '0;
    end else begin
      flags_q[0] <= {fetch_enable_i, err_i, rvalid_i, gnt_i};
      rdata_q[0] <= rdata_i;
      for (int unsigned i = 1; i < LOCKSTEP_OFFSET; i++) begin
        flags_q[i] <= flags_q[i-1];
        rdata_q[i] <= rdata_q[i-1];
      end
      rdata_intg_q <= rdata_intg_i;
    end
  end

  // Last stage feeds the shadow core
  assign gnt_o          = flags_q[LOCKSTEP_OFFSET-1][0];
  assign rvalid_o       = flags_q[LOCKSTEP_OFFSET-1][1];
  assign err_o          = flags_q[LOCKSTEP_OFFSET-1][2];
  assign fetch_enable_o = flags_q[LOCKSTEP_OFFSET-1][3];
  assign rdata_o        = rdata_q[LOCKSTEP_OFFSET-1];

  // First stage goes to the integrity check
  assign rvalid_d1_o     = flags_q[0][1];
  assign rdata_d1_o      = rdata_q[0];
  assign rdata_intg_d1_o = rdata_intg_q;

endmodule

/* shadow_reset_ctrl.sv */
// Offset counter that releases the shadow core reset and enables output comparison
module shadow_reset_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic enable_cmp_o
);
  import lockstep_pkg::*;

  logic [OFFSET_CNT_W-1:0] cnt_q;
  logic [OFFSET_CNT_W-1:0] cnt_d;
  logic                    shadow_set_d;
  logic                    shadow_set_q;
  logic                    enable_cmp_q;

  // Counter stops once the offset has elapsed
  assign shadow_set_d = (cnt_q == OFFSET_CNT_W'(LOCKSTEP_OFFSET - 1));
  assign cnt_d        = shadow_set_d ? cnt_q : cnt_q + OFFSET_CNT_W'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      shadow_set_q <= 1'b0;
      enable_cmp_q <= 1'b0;
    end else begin
      cnt_q        <= cnt_d;
      shadow_set_q <= shadow_set_d;
      // Shadow outputs are registered, so compare one cycle after release
      enable_cmp_q <= shadow_set_q;
    end
  end

  // Asserted asynchronously with rst_ni, released on a clock edge
  assign rst_shadow_no = shadow_set_q;
  assign enable_cmp_o  = enable_cmp_q;

endmodule

/* lockstep_pkg.sv */
// Lockstep offsets, bus widths, SECDED masks, opcode and core state enums
package lockstep_pkg;

  //////////////////////////////
  // Lockstep timing

  // Cycles the shadow core runs behind the main core
  localparam int unsigned LOCKSTEP_OFFSET = 2;
  // Shadow outputs pass through one extra register
  localparam int unsigned OUTPUTS_OFFSET = LOCKSTEP_OFFSET + 1;
  localparam int unsigned OFFSET_CNT_W =
      (LOCKSTEP_OFFSET > 1) ? $clog2(LOCKSTEP_OFFSET) : 1;

  //////////////////////////////
  // Bus widths

  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned BE_W   = 4;
  localparam int unsigned INTG_W = 7;

  //////////////////////////////
  // Hsiao SECDED 39/32 check bit masks

  localparam logic [DATA_W-1:0] SECDED_MASK_0 = 32'h2606_BD25;
  localparam logic [DATA_W-1:0] SECDED_MASK_1 = 32'hDEBA_8050;
  localparam logic [DATA_W-1:0] SECDED_MASK_2 = 32'h413D_89AA;
  localparam logic [DATA_W-1:0] SECDED_MASK_3 = 32'h3123_4ED1;
  localparam logic [DATA_W-1:0] SECDED_MASK_4 = 32'hC2C1_323B;
  localparam logic [DATA_W-1:0] SECDED_MASK_5 = 32'h2DCC_624C;
  localparam logic [DATA_W-1:0] SECDED_MASK_6 = 32'h9850_5586;

  // Keeps an all-zero word from being a valid codeword
  localparam logic [INTG_W-1:0] INTG_INVERT = 7'h2A;

  // Opcode field in bits 31:30 of every word the core reads
  typedef enum logic [1:0] {
    OP_ADD   = 2'b00,
    OP_XOR   = 2'b01,
    OP_STORE = 2'b10,
    OP_HALT  = 2'b11
  } opcode_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_REQ  = 2'b01,
    ST_WAIT = 2'b10,
    ST_DONE = 2'b11
  } core_state_e;

endpackage
